//--- all.f
hdl/l2bus_pkg.sv
hdl/line_buffer.sv
hdl/req_channel.sv
hdl/snoop_channel.sv
hdl/bus_slot_seq.sv
hdl/l2trans.sv
verif/l2trans_checker.sv
verif/l2trans_tb.sv

//--- hdl/bus_slot_seq.sv
// free-running slot counter from reset; a sent snoop always owns the bus fields
`timescale 1ns/1ps

module bus_slot_seq (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   slot_last,
  input  logic                   req_want,
  input  logic                   req_sent,
  input  l2bus_pkg::cmd_t        req_cmd,
  input  l2bus_pkg::bus_tag_t    req_tag,
  input  l2bus_pkg::line_addr_t  req_addr,
  input  l2bus_pkg::beat_t       req_data,
  input  logic                   snoop_want,
  input  logic                   snoop_sent,
  input  l2bus_pkg::bus_tag_t    snoop_tag,
  input  l2bus_pkg::line_addr_t  snoop_addr,
  input  l2bus_pkg::beat_t       snoop_data,
  output logic                   l2_bus_req,
  output l2bus_pkg::cmd_t        l2_bus_cmd,
  output l2bus_pkg::bus_tag_t    l2_bus_tag,
  output l2bus_pkg::line_addr_t  l2_bus_addr,
  output l2bus_pkg::beat_t       l2_bus_data
);

  logic [$clog2(l2bus_pkg::slot_cycles)-1:0] cycle_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_r <= '0;
    end else begin
      cycle_r <= cycle_r + 1'b1;
    end
  end

  // grant and nack are only valid here
  assign slot_last = int'(cycle_r) == l2bus_pkg::slot_cycles - 1;

  assign l2_bus_req = req_want || snoop_want;

  always_comb begin
    if (snoop_sent) begin
      // snoop responses always go out as a flush
      l2_bus_cmd  = l2bus_pkg::cmd_flush;
      l2_bus_tag  = snoop_tag;
      l2_bus_addr = snoop_addr;
      l2_bus_data = snoop_data;
    end else begin
      l2_bus_cmd  = req_cmd;
      l2_bus_tag  = req_tag;
      l2_bus_addr = req_addr;
      // idle data lines when nothing is in its data phase
      l2_bus_data = req_sent ? req_data : '0;
    end
  end

  // one grant per slot, so only one channel can be in its data phase
  a_one_sender: assert property (@(posedge clk) disable iff (rst)
    !(req_sent && snoop_sent));

endmodule

//--- hdl/l2bus_pkg.sv
// bus encodings and slot constants; one 8-beat line per 8-cycle slot, request tags wrap after 8
package l2bus_pkg;

  // bus command codes
  typedef enum logic [2:0] {
    cmd_busrd   = 3'd1,
    cmd_busrdx  = 3'd2,
    cmd_busupgr = 3'd3,
    cmd_flush   = 3'd4
  } cmd_t;

  // line address, offset bits dropped
  typedef logic [31:6] line_addr_t;

  typedef logic [63:0] beat_t;

  // bus tag is {bus id, request tag} for own requests
  typedef logic [4:0] bus_tag_t;

  typedef logic [2:0] req_tag_t;

  typedef logic [2:0] beat_idx_t;

  // bus identity of this cache
  localparam logic [1:0] busid_l2 = 2'd2;

  localparam int line_beats = 8;

  // data phase puts beat k out in slot cycle k
  localparam int slot_cycles = 8;

endpackage

//--- hdl/l2trans.sv
// l2 bus transmitter; one own request and one snoop response in flight, no pending tag tracking
`timescale 1ns/1ps

module l2trans (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   l2data_req_valid,
  input  l2bus_pkg::cmd_t        l2data_req_cmd,
  input  l2bus_pkg::line_addr_t  l2data_req_addr,
  input  l2bus_pkg::beat_t       l2data_req_data,
  output logic                   l2trans_l2data_req_ready,

  input  logic                   l2data_snoop_valid,
  input  l2bus_pkg::bus_tag_t    l2data_snoop_tag,
  input  l2bus_pkg::line_addr_t  l2data_snoop_addr,
  input  l2bus_pkg::beat_t       l2data_snoop_data,
  output logic                   l2trans_l2data_snoop_ready,

  input  logic                   l2tag_inv_valid,
  input  l2bus_pkg::line_addr_t  l2tag_inv_addr,
  output logic                   l2trans_flush_hit,

  output logic                   l2trans_valid,
  output l2bus_pkg::req_tag_t    l2trans_tag,

  output logic                   l2_bus_req,
  output l2bus_pkg::cmd_t        l2_bus_cmd,
  output l2bus_pkg::bus_tag_t    l2_bus_tag,
  output l2bus_pkg::line_addr_t  l2_bus_addr,
  output l2bus_pkg::beat_t       l2_bus_data,
  input  logic                   bus_l2_grant,
  input  logic                   bus_nack
);

  logic slot_last;

  logic                  req_want;
  logic                  req_sent;
  l2bus_pkg::cmd_t       req_bus_cmd;
  l2bus_pkg::bus_tag_t   req_bus_tag;
  l2bus_pkg::line_addr_t req_bus_addr;
  l2bus_pkg::beat_t      req_bus_data;

  logic                  snoop_want;
  logic                  snoop_sent;
  logic                  snoop_busy;
  l2bus_pkg::bus_tag_t   snoop_bus_tag;
  l2bus_pkg::line_addr_t snoop_bus_addr;
  l2bus_pkg::beat_t      snoop_bus_data;

  req_channel req_channel_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (l2data_req_valid),
    .req_cmd    (l2data_req_cmd),
    .req_addr   (l2data_req_addr),
    .req_data   (l2data_req_data),
    .req_ready  (l2trans_l2data_req_ready),
    .inv_valid  (l2tag_inv_valid),
    .inv_addr   (l2tag_inv_addr),
    .flush_hit  (l2trans_flush_hit),
    .done       (l2trans_valid),
    .tag        (l2trans_tag),
    .slot_last  (slot_last),
    .grant      (bus_l2_grant),
    .nack       (bus_nack),
    .snoop_busy (snoop_busy),
    .want_bus   (req_want),
    .sent       (req_sent),
    .bus_cmd    (req_bus_cmd),
    .bus_tag    (req_bus_tag),
    .bus_addr   (req_bus_addr),
    .bus_data   (req_bus_data)
  );

  snoop_channel snoop_channel_i (
    .clk         (clk),
    .rst         (rst),
    .snoop_valid (l2data_snoop_valid),
    .snoop_tag   (l2data_snoop_tag),
    .snoop_addr  (l2data_snoop_addr),
    .snoop_data  (l2data_snoop_data),
    .snoop_ready (l2trans_l2data_snoop_ready),
    .slot_last   (slot_last),
    .grant       (bus_l2_grant),
    .want_bus    (snoop_want),
    .sent        (snoop_sent),
    .busy        (snoop_busy),
    .bus_tag     (snoop_bus_tag),
    .bus_addr    (snoop_bus_addr),
    .bus_data    (snoop_bus_data)
  );

  bus_slot_seq bus_slot_seq_i (
    .clk         (clk),
    .rst         (rst),
    .slot_last   (slot_last),
    .req_want    (req_want),
    .req_sent    (req_sent),
    .req_cmd     (req_bus_cmd),
    .req_tag     (req_bus_tag),
    .req_addr    (req_bus_addr),
    .req_data    (req_bus_data),
    .snoop_want  (snoop_want),
    .snoop_sent  (snoop_sent),
    .snoop_tag   (snoop_bus_tag),
    .snoop_addr  (snoop_bus_addr),
    .snoop_data  (snoop_bus_data),
    .l2_bus_req  (l2_bus_req),
    .l2_bus_cmd  (l2_bus_cmd),
    .l2_bus_tag  (l2_bus_tag),
    .l2_bus_addr (l2_bus_addr),
    .l2_bus_data (l2_bus_data)
  );

endmodule

//--- hdl/line_buffer.sv
// one 8-beat line; a new line may start only on the beat that drains the old one
`timescale 1ns/1ps

module line_buffer (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_beat,
  input  l2bus_pkg::beat_t  wr_data,
  input  logic              rd_beat,
  input  logic              rd_hold,
  output logic              full,
  output l2bus_pkg::beat_t  rd_data
);

  l2bus_pkg::beat_t mem [l2bus_pkg::line_beats];

  l2bus_pkg::beat_idx_t idx_r;
  l2bus_pkg::beat_idx_t wr_idx;
  logic                 full_r;
  logic                 last_beat;
  logic                 drain_last;

  assign last_beat = int'(idx_r) == l2bus_pkg::line_beats - 1;

  // last beat read out and no nack, line is gone after this edge
  assign drain_last = rd_beat && last_beat && !rd_hold;

  // hand-over cycle: old line still full, new line starts at beat 0
  assign wr_idx = full_r ? '0 : idx_r;

  always_ff @(posedge clk) begin
    if (wr_beat) begin
      mem[wr_idx] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      idx_r  <= '0;
      full_r <= 1'b0;
    end else if (wr_beat) begin
      idx_r  <= wr_idx + 3'd1;
      full_r <= int'(wr_idx) == l2bus_pkg::line_beats - 1;
    end else if (rd_beat) begin
      // on a nack the index just wraps and the line replays
      idx_r <= idx_r + 3'd1;
      if (drain_last) begin
        full_r <= 1'b0;
      end
    end
  end

  assign full    = full_r;
  assign rd_data = mem[idx_r];

  // the producer may only overlap the final drained beat
  a_no_write_full: assert property (@(posedge clk) disable iff (rst)
    wr_beat && full_r |-> drain_last);

endmodule

//--- hdl/req_channel.sv
// holds one own request at a time; flush data must arrive on consecutive cycles after the command
`timescale 1ns/1ps

module req_channel (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid,
  input  l2bus_pkg::cmd_t        req_cmd,
  input  l2bus_pkg::line_addr_t  req_addr,
  input  l2bus_pkg::beat_t       req_data,
  output logic                   req_ready,
  input  logic                   inv_valid,
  input  l2bus_pkg::line_addr_t  inv_addr,
  output logic                   flush_hit,
  output logic                   done,
  output l2bus_pkg::req_tag_t    tag,
  input  logic                   slot_last,
  input  logic                   grant,
  input  logic                   nack,
  input  logic                   snoop_busy,
  output logic                   want_bus,
  output logic                   sent,
  output l2bus_pkg::cmd_t        bus_cmd,
  output l2bus_pkg::bus_tag_t    bus_tag,
  output l2bus_pkg::line_addr_t  bus_addr,
  output l2bus_pkg::beat_t       bus_data
);

  logic                  held_r;
  logic                  sent_r;
  l2bus_pkg::cmd_t       cmd_r;
  l2bus_pkg::line_addr_t addr_r;
  l2bus_pkg::req_tag_t   tag_r;

  logic is_flush;
  logic buf_full;
  logic filling;
  logic wr_beat;
  logic rd_beat;
  logic inv_hit;
  logic upgr_hit;
  logic granted;
  logic yield;

  assign is_flush = cmd_r == l2bus_pkg::cmd_flush;

  assign inv_hit   = inv_valid && held_r && inv_addr == addr_r;
  assign flush_hit = inv_hit && is_flush;
  assign upgr_hit  = inv_hit && cmd_r == l2bus_pkg::cmd_busupgr;

  assign sent     = held_r && sent_r;
  // non-flush requests carry no data, so they are always ready to go
  assign want_bus = held_r && !sent_r && (!is_flush || buf_full);
  assign done     = sent && slot_last && !nack;
  assign req_ready = !held_r || done;

  assign granted = want_bus && slot_last && grant && !snoop_busy;
  // snoop won the next slot over a nacked request, ask again later
  assign yield   = sent && slot_last && nack && grant && snoop_busy;

  // first beat comes with the command, the rest follow without ready
  assign filling = held_r && is_flush && !sent_r && !buf_full;
  assign wr_beat = req_valid &&
                   ((req_ready && req_cmd == l2bus_pkg::cmd_flush) || filling);
  assign rd_beat = sent && is_flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_r <= 1'b0;
      sent_r <= 1'b0;
    end else if (req_ready) begin
      held_r <= req_valid;
      sent_r <= 1'b0;
    end else if (granted) begin
      sent_r <= 1'b1;
    end else if (yield) begin
      sent_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready && req_valid) begin
      cmd_r  <= req_cmd;
      addr_r <= req_addr;
    end else if (upgr_hit) begin
      // line lost meanwhile, upgrade must fetch it again
      cmd_r <= l2bus_pkg::cmd_busrdx;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_r <= '0;
    end else if (done) begin
      tag_r <= tag_r + 3'd1;
    end
  end

  line_buffer line_buf_i (
    .clk     (clk),
    .rst     (rst),
    .wr_beat (wr_beat),
    .wr_data (req_data),
    .rd_beat (rd_beat),
    .rd_hold (nack),
    .full    (buf_full),
    .rd_data (bus_data)
  );

  assign tag      = tag_r;
  assign bus_cmd  = upgr_hit ? l2bus_pkg::cmd_busrdx : cmd_r;
  assign bus_tag  = {l2bus_pkg::busid_l2, tag_r};
  assign bus_addr = addr_r;

  // completion closes a whole sent slot and a flush still holds its line
  a_done_sent: assert property (@(posedge clk) disable iff (rst)
    done |-> $past(sent, l2bus_pkg::slot_cycles - 1) && (!is_flush || buf_full));

endmodule

//--- hdl/snoop_channel.sv
// holds one snoop response with its full line; nack is ignored, the response goes out once
`timescale 1ns/1ps

module snoop_channel (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   snoop_valid,
  input  l2bus_pkg::bus_tag_t    snoop_tag,
  input  l2bus_pkg::line_addr_t  snoop_addr,
  input  l2bus_pkg::beat_t       snoop_data,
  output logic                   snoop_ready,
  input  logic                   slot_last,
  input  logic                   grant,
  output logic                   want_bus,
  output logic                   sent,
  output logic                   busy,
  output l2bus_pkg::bus_tag_t    bus_tag,
  output l2bus_pkg::line_addr_t  bus_addr,
  output l2bus_pkg::beat_t       bus_data
);

  logic                  held_r;
  logic                  sent_r;
  l2bus_pkg::bus_tag_t   tag_r;
  l2bus_pkg::line_addr_t addr_r;

  logic buf_full;
  logic filling;
  logic wr_beat;

  assign sent     = held_r && sent_r;
  // only ask once the whole line is in
  assign want_bus = held_r && !sent_r && buf_full;
  assign busy     = want_bus || sent;

  // freed at the end of the sent slot
  assign snoop_ready = !held_r || (sent && slot_last);

  assign filling = held_r && !sent_r && !buf_full;
  assign wr_beat = snoop_valid && (snoop_ready || filling);

  always_ff @(posedge clk) begin
    if (rst) begin
      held_r <= 1'b0;
      sent_r <= 1'b0;
    end else if (snoop_ready) begin
      held_r <= snoop_valid;
      sent_r <= 1'b0;
    end else if (want_bus && slot_last && grant) begin
      sent_r <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (snoop_ready && snoop_valid) begin
      tag_r  <= snoop_tag;
      addr_r <= snoop_addr;
    end
  end

  line_buffer line_buf_i (
    .clk     (clk),
    .rst     (rst),
    .wr_beat (wr_beat),
    .wr_data (snoop_data),
    .rd_beat (sent),
    .rd_hold (1'b0),
    .full    (buf_full),
    .rd_data (bus_data)
  );

  assign bus_tag  = tag_r;
  assign bus_addr = addr_r;

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the l2trans testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module l2trans_tb \
  -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/Vl2trans_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0

//--- verif/l2trans_checker.sv
// samples 1 ns before each rising edge; data beats are compared only in flush slots
`timescale 1ns/1ps

module l2trans_checker (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [2:0]             cyc,
  input  logic                   data_phase,
  input  l2bus_pkg::cmd_t        exp_cmd,
  input  l2bus_pkg::bus_tag_t    exp_tag,
  input  l2bus_pkg::line_addr_t  exp_addr,
  input  l2bus_pkg::beat_t       exp_data [8],
  input  logic                   exp_hit,
  input  logic                   l2_bus_req,
  input  l2bus_pkg::cmd_t        l2_bus_cmd,
  input  l2bus_pkg::bus_tag_t    l2_bus_tag,
  input  l2bus_pkg::line_addr_t  l2_bus_addr,
  input  l2bus_pkg::beat_t       l2_bus_data,
  input  logic                   bus_nack,
  input  logic                   l2tag_inv_valid,
  input  logic                   l2trans_flush_hit,
  input  logic                   l2trans_valid,
  input  l2bus_pkg::req_tag_t    l2trans_tag,
  input  logic                   l2trans_l2data_req_ready,
  input  logic                   l2trans_l2data_snoop_ready,
  output int                     checks,
  output int                     errors
);

  int   n_checks = 0;
  int   n_errors = 0;
  logic own_phase;
  logic own_done;

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  always begin
    @(negedge clk);
    #1;
    if (rst) begin
      // idle state, nothing requested and both sides ready
      compare_value("l2_bus_req", 64'(l2_bus_req), 64'(1'b0));
      compare_value("l2trans_l2data_req_ready", 64'(l2trans_l2data_req_ready),
                    64'(1'b1));
      compare_value("l2trans_l2data_snoop_ready", 64'(l2trans_l2data_snoop_ready),
                    64'(1'b1));
      compare_value("l2trans_valid", 64'(l2trans_valid), 64'(1'b0));
    end else begin
      own_phase = data_phase && exp_tag[4:3] == l2bus_pkg::busid_l2;
      // own request completes at the end of a slot without nack
      own_done = own_phase && cyc == 3'd7 && !bus_nack;
      if (data_phase) begin
        compare_value("l2_bus_cmd", 64'(l2_bus_cmd), 64'(exp_cmd));
        compare_value("l2_bus_tag", 64'(l2_bus_tag), 64'(exp_tag));
        compare_value("l2_bus_addr", 64'(l2_bus_addr), 64'(exp_addr));
        if (exp_cmd == l2bus_pkg::cmd_flush) begin
          compare_value("l2_bus_data", l2_bus_data, exp_data[cyc]);
        end
      end
      if (own_phase) begin
        // a sent request holds its command and asks for no further slot
        compare_value("l2_bus_req", 64'(l2_bus_req), 64'(1'b0));
        compare_value("l2trans_l2data_req_ready", 64'(l2trans_l2data_req_ready),
                      64'(own_done));
      end else if (data_phase) begin
        // snoop is freed in the last cycle of its slot
        compare_value("l2trans_l2data_snoop_ready", 64'(l2trans_l2data_snoop_ready),
                      64'(cyc == 3'd7));
      end
      compare_value("l2trans_valid", 64'(l2trans_valid), 64'(own_done));
      if (own_done) begin
        compare_value("l2trans_tag", 64'(l2trans_tag), 64'(exp_tag[2:0]));
      end
      compare_value("l2trans_flush_hit", 64'(l2trans_flush_hit),
                    64'(l2tag_inv_valid && exp_hit));
    end
  end

  assign checks = n_checks;
  assign errors = n_errors;

endmodule

//--- verif/l2trans_tb.sv
// bus model grants one slot at a time, never back to back; snoop tags must not carry busid_l2
`timescale 1ns/1ps

module l2trans_tb;

  typedef struct packed {
    logic                  snoop;
    l2bus_pkg::cmd_t       cmd;
    l2bus_pkg::line_addr_t addr;
    l2bus_pkg::bus_tag_t   stag;
    logic [1:0]            nacks;
    // 0 none, 1 same line, 2 other line
    logic [1:0]            inv;
    l2bus_pkg::cmd_t       exp_cmd;
    l2bus_pkg::bus_tag_t   exp_tag;
    logic                  exp_hit;
  } case_t;

  logic clk = 1'b0;
  logic rst;
  logic l2data_req_valid;
  l2bus_pkg::cmd_t l2data_req_cmd;
  l2bus_pkg::line_addr_t l2data_req_addr;
  l2bus_pkg::beat_t l2data_req_data;
  logic l2trans_l2data_req_ready;
  logic l2data_snoop_valid;
  l2bus_pkg::bus_tag_t l2data_snoop_tag;
  l2bus_pkg::line_addr_t l2data_snoop_addr;
  l2bus_pkg::beat_t l2data_snoop_data;
  logic l2trans_l2data_snoop_ready;
  logic l2tag_inv_valid;
  l2bus_pkg::line_addr_t l2tag_inv_addr;
  logic l2trans_flush_hit;
  logic l2trans_valid;
  l2bus_pkg::req_tag_t l2trans_tag;
  logic l2_bus_req;
  l2bus_pkg::cmd_t l2_bus_cmd;
  l2bus_pkg::bus_tag_t l2_bus_tag;
  l2bus_pkg::line_addr_t l2_bus_addr;
  l2bus_pkg::beat_t l2_bus_data;
  logic bus_l2_grant = 1'b0;
  logic bus_nack = 1'b0;

  logic [2:0] cyc;
  logic in_data;
  int nack_goal;
  int nack_given = 0;
  l2bus_pkg::cmd_t exp_cmd;
  l2bus_pkg::bus_tag_t exp_tag;
  l2bus_pkg::line_addr_t exp_addr;
  l2bus_pkg::beat_t exp_data [8];
  logic exp_hit;
  case_t cases [9];
  case_t c;
  integer seed;
  l2bus_pkg::req_tag_t tag_cnt;
  logic timed_out;
  int checks;
  int errors;

  always #2 clk = ~clk;

  l2trans l2trans_i (.*);

  l2trans_checker checker_i (
    .clk                        (clk),
    .rst                        (rst),
    .cyc                        (cyc),
    .data_phase                 (in_data),
    .exp_cmd                    (exp_cmd),
    .exp_tag                    (exp_tag),
    .exp_addr                   (exp_addr),
    .exp_data                   (exp_data),
    .exp_hit                    (exp_hit),
    .l2_bus_req                 (l2_bus_req),
    .l2_bus_cmd                 (l2_bus_cmd),
    .l2_bus_tag                 (l2_bus_tag),
    .l2_bus_addr                (l2_bus_addr),
    .l2_bus_data                (l2_bus_data),
    .bus_nack                   (bus_nack),
    .l2tag_inv_valid            (l2tag_inv_valid),
    .l2trans_flush_hit          (l2trans_flush_hit),
    .l2trans_valid              (l2trans_valid),
    .l2trans_tag                (l2trans_tag),
    .l2trans_l2data_req_ready   (l2trans_l2data_req_ready),
    .l2trans_l2data_snoop_ready (l2trans_l2data_snoop_ready),
    .checks                     (checks),
    .errors                     (errors)
  );

  // slot position and data phase as the arbiter sees them
  always @(posedge clk) begin
    if (rst) begin
      cyc     <= 3'd0;
      in_data <= 1'b0;
    end else begin
      cyc <= cyc + 3'd1;
      if (cyc == 3'd7) begin
        in_data <= bus_l2_grant || (in_data && bus_nack);
      end
    end
  end

  always @(negedge clk) begin
    bus_l2_grant <= !rst && cyc == 3'd7 && l2_bus_req && !in_data;
    if (cyc == 3'd7 && in_data && l2_bus_tag[4:3] == l2bus_pkg::busid_l2 &&
        nack_given < nack_goal) begin
      bus_nack   <= 1'b1;
      nack_given <= nack_given + 1;
    end else begin
      bus_nack <= 1'b0;
      if (!in_data) begin
        nack_given <= 0;
      end
    end
  end

  task automatic wait_phase(input logic level);
    int n;
    n = 0;
    while (!timed_out && in_data !== level && n < 48) begin
      @(negedge clk);
      n++;
    end
    if (!timed_out && in_data !== level) begin
      timed_out = 1'b1;
      $display("timeout: bus data phase did not %s", level ? "start" : "end");
    end
  endtask

  task automatic wait_ready(input logic snoop);
    int n;
    n = 0;
    @(negedge clk);
    while (!timed_out && n < 48 &&
           !(snoop ? l2trans_l2data_snoop_ready : l2trans_l2data_req_ready)) begin
      @(negedge clk);
      n++;
    end
    if (!(snoop ? l2trans_l2data_snoop_ready : l2trans_l2data_req_ready)) begin
      timed_out = 1'b1;
      $display("timeout: transmitter never became ready to take a %s",
               snoop ? "snoop" : "request");
    end
  endtask

  task automatic send_req(input l2bus_pkg::cmd_t cmd, input l2bus_pkg::line_addr_t addr,
                          input logic [1:0] inv);
    int k;
    int beats;
    beats = (cmd == l2bus_pkg::cmd_flush) ? 8 : 2;
    if (cmd == l2bus_pkg::cmd_flush) begin
      for (k = 0; k < 8; k++) begin
        exp_data[k] = {$random(seed), $random(seed)};
      end
    end
    wait_ready(1'b0);
    l2data_req_valid = 1'b1;
    l2data_req_cmd   = cmd;
    l2data_req_addr  = addr;
    l2data_req_data  = exp_data[0];
    for (k = 1; k < beats; k++) begin
      @(negedge clk);
      l2data_req_valid = cmd == l2bus_pkg::cmd_flush;
      l2data_req_data  = exp_data[k];
      l2tag_inv_valid  = k == 1 && inv != 2'd0;
      l2tag_inv_addr   = (inv == 2'd2) ? (addr ^ 26'h1) : addr;
    end
    @(negedge clk);
    l2data_req_valid = 1'b0;
    l2tag_inv_valid  = 1'b0;
  endtask

  task automatic send_snoop(input l2bus_pkg::bus_tag_t tag, input l2bus_pkg::line_addr_t addr);
    int k;
    for (k = 0; k < 8; k++) begin
      exp_data[k] = {$random(seed), $random(seed)};
    end
    wait_ready(1'b1);
    l2data_snoop_valid = 1'b1;
    l2data_snoop_tag   = tag;
    l2data_snoop_addr  = addr;
    for (k = 0; k < 8; k++) begin
      l2data_snoop_data = exp_data[k];
      @(negedge clk);
    end
    l2data_snoop_valid = 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    l2data_req_valid = 1'b0;
    l2data_req_cmd = l2bus_pkg::cmd_busrd;
    l2data_req_addr = '0;
    l2data_req_data = '0;
    l2data_snoop_valid = 1'b0;
    l2data_snoop_tag = '0;
    l2data_snoop_addr = '0;
    l2data_snoop_data = '0;
    l2tag_inv_valid = 1'b0;
    l2tag_inv_addr = '0;
    nack_goal = 0;
    exp_cmd = l2bus_pkg::cmd_busrd;
    exp_tag = '0;
    exp_addr = '0;
    exp_hit = 1'b0;
    for (int k = 0; k < 8; k++) begin
      exp_data[k] = '0;
    end
    seed = 32'hf6f3f253;
    tag_cnt = '0;
    timed_out = 1'b0;

    cases[0] = '{1'b0, l2bus_pkg::cmd_busrd, 26'h0123456, 5'h00, 2'd0, 2'd0,
                 l2bus_pkg::cmd_busrd, 5'h10, 1'b0};
    cases[1] = '{1'b0, l2bus_pkg::cmd_flush, 26'h0abcdef, 5'h00, 2'd0, 2'd0,
                 l2bus_pkg::cmd_flush, 5'h11, 1'b0};
    cases[2] = '{1'b0, l2bus_pkg::cmd_flush, 26'h2000040, 5'h00, 2'd2, 2'd0,
                 l2bus_pkg::cmd_flush, 5'h12, 1'b0};
    // snoop row, the read that follows uses the next own tag
    cases[3] = '{1'b1, l2bus_pkg::cmd_busrd, 26'h1555555, 5'h0b, 2'd0, 2'd0,
                 l2bus_pkg::cmd_flush, 5'h0b, 1'b0};
    cases[4] = '{1'b0, l2bus_pkg::cmd_flush, 26'h0333330, 5'h00, 2'd0, 2'd1,
                 l2bus_pkg::cmd_flush, 5'h14, 1'b1};
    cases[5] = '{1'b0, l2bus_pkg::cmd_busupgr, 26'h3fedcba, 5'h00, 2'd0, 2'd1,
                 l2bus_pkg::cmd_busrdx, 5'h15, 1'b0};
    cases[6] = '{1'b0, l2bus_pkg::cmd_busupgr, 26'h0777770, 5'h00, 2'd0, 2'd2,
                 l2bus_pkg::cmd_busupgr, 5'h16, 1'b0};
    cases[7] = '{1'b0, l2bus_pkg::cmd_flush, 26'h1000001, 5'h00, 2'd1, 2'd2,
                 l2bus_pkg::cmd_flush, 5'h17, 1'b0};
    // tag wraps back to 0
    cases[8] = '{1'b0, l2bus_pkg::cmd_busrd, 26'h0000abc, 5'h00, 2'd0, 2'd0,
                 l2bus_pkg::cmd_busrd, 5'h10, 1'b0};

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < 9 && !timed_out; i++) begin
      c = cases[i];
      nack_goal = int'(c.nacks);
      exp_hit   = c.exp_hit;
      exp_cmd   = c.exp_cmd;
      exp_tag   = c.exp_tag;
      exp_addr  = c.addr;
      if (c.snoop) begin
        send_snoop(c.stag, c.addr);
        send_req(c.cmd, c.addr ^ 26'h1, 2'd0);
        wait_phase(1'b1);
        wait_phase(1'b0);
        exp_cmd  = c.cmd;
        exp_tag  = {l2bus_pkg::busid_l2, tag_cnt};
        exp_addr = c.addr ^ 26'h1;
      end else begin
        send_req(c.cmd, c.addr, c.inv);
      end
      wait_phase(1'b1);
      wait_phase(1'b0);
      tag_cnt++;
    end

    repeat (4) @(negedge clk);
    $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, int'(timed_out));
    if (errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
